// File: cache_top.f
source/cache_pkg.sv
source/sram_sp_32x128_bw.sv
source/cache_sram.sv
source/cache_tag.sv
source/cache_ctrl.sv
source/cache_top.sv
tb/cache_mem_model.sv
tb/cache_chk.sv
tb/cache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -sv --assert --timing -Wno-fatal \
    -f cache_top.f --top-module cache_tb -o cache_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cache_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: tb/cache_tb.sv
// Cache testbench top with clock, reset, watchdog, bus monitor and directed tests
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
;
    localparam int          CLK_PERIOD = 4;
    localparam int          RST_CYCLES = 4;
    localparam int          MEM_LAT    = 6;
    localparam logic [31:0] SEED       = 32'hd4e5;
    localparam int          ACC_MAX    = 100;  // Cycles allowed per access
    localparam int          NUM_ACC    = 60;   // Upper bound on accesses in all tests

    logic clk, rst_n, fill_en;
    logic cpu_req, cpu_we, cpu_done, cpu_busy;
    logic [ADDR_W-1:0] cpu_addr, mem_addr;
    logic [DATA_W-1:0] cpu_wdata, cpu_rdata, mem_rdata, mem_wdata;
    logic [STRB_W-1:0] cpu_wstrb;
    logic mem_rd, mem_rvalid, mem_wvalid;
    logic [31:0] key;

    logic [7:0]  shadow [logic [31:0]];        // Bytes written by the CPU
    logic [63:0] wb_data [8];                  // Last writeback block
    logic [31:0] wb_addr, rd_addr;
    int          wb_cnt, rd_cnt, wb_beat;
    int          errors, checks, tests, failed;

    cache_top UUT (.*);

    cache_mem_model #(.LATENCY(MEM_LAT)) u_mem (
        .clk(clk), .rst_n(rst_n), .fill_en(fill_en), .fill_key(key),
        .mem_rd(mem_rd), .mem_addr(mem_addr), .mem_rvalid(mem_rvalid),
        .mem_rdata(mem_rdata), .mem_wvalid(mem_wvalid), .mem_wdata(mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_ACC * ACC_MAX * CLK_PERIOD * 2 + RST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("TB FAILED");
        $finish;
    end

    // Memory bus monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && mem_rd) begin
            rd_cnt++;
            rd_addr = mem_addr;
        end
        if (rst_n && mem_wvalid) begin
            if (wb_beat == 0) wb_addr = mem_addr;
            wb_data[wb_beat] = mem_wdata;
            wb_beat = (wb_beat + 1) % 8;
            if (wb_beat == 0) wb_cnt++;
        end
    end

    // Initial memory contents per doubleword index
    function automatic logic [63:0] fill_word(input logic [12:0] idx);
        return {key ^ (idx * 32'h9e3779b1), ~key ^ (idx * 32'h7f4a7c15) ^ 32'(idx)};
    endfunction

    function automatic logic [63:0] exp_dw(input logic [31:0] addr);
        logic [63:0] v;
        logic [31:0] a;
        v = fill_word(addr[15:3]);
        for (int i = 0; i < 8; i++) begin
            a = {addr[31:3], 3'b000} + i;
            if (shadow.exists(a)) v[i*8 +: 8] = shadow[a];
        end
        return v;
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    // One CPU access, returns data and cycles from cpu_req to cpu_done
    task automatic cpu_access(input logic we, input logic [31:0] addr, input logic [63:0] wdata,
                              input logic [7:0] strb, output logic [63:0] rdata, output int lat);
        int n;
        @(posedge clk);
        #1;
        check_eq(64'(cpu_busy), 64'd0, "cpu_busy before cpu_req");
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_wstrb = strb;
        for (int i = 0; i < 8; i++) begin
            if (we && strb[i]) shadow[{addr[31:3], 3'b000} + i] = wdata[i*8 +: 8];
        end
        @(posedge clk);
        #1;
        cpu_req = 1'b0;
        check_eq(64'(cpu_busy), 64'd1, "cpu_busy after cpu_req");
        n = 1;
        while (!cpu_done && n < ACC_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!cpu_done) begin
            $display("No cpu_done for address %h within %0d cycles", addr, ACC_MAX);
            errors++;
        end
        lat   = n;
        rdata = cpu_rdata;
    endtask

    task automatic read_check(input logic [31:0] addr, output int lat);
        logic [63:0] d;
        cpu_access(1'b0, addr, '0, '0, d, lat);
        check_eq(d, exp_dw(addr), $sformatf("read %h", addr));
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [7:0] strb, output int lat);
        logic [63:0] d;
        cpu_access(1'b1, addr, {$urandom, $urandom}, strb, d, lat);
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        if (errors != err_before) failed++;
        $display("test %0d %-26s %s", tests, name, (errors == err_before) ? "ok" : "failed");
    endtask

    task automatic test_read_miss_hit();
        int e, lat, r0;
        e  = errors;
        r0 = rd_cnt;
        read_check(32'h0000_1048, lat);
        check_eq(64'(rd_cnt - r0), 64'd1, "mem_rd count on miss");
        check_eq(64'(rd_addr), 64'h1040, "refill address");
        read_check(32'h0000_1070, lat);
        check_eq(64'(lat), 64'd2, "hit latency");
        check_eq(64'(rd_cnt - r0), 64'd1, "mem_rd count on hit");
        report("read miss then hit", e);
    endtask

    task automatic test_write_hit();
        int e, lat;
        e = errors;
        write_word(32'h0000_1048, 8'b1010_0101, lat);
        check_eq(64'(lat), 64'd2, "write hit latency");
        write_word(32'h0000_1078, 8'b0001_1000, lat);
        read_check(32'h0000_1048, lat);
        check_eq(64'(lat), 64'd2, "read after write latency");
        read_check(32'h0000_1078, lat);
        report("write hit partial strobes", e);
    endtask

    task automatic test_write_miss();
        int e, lat, r0;
        e  = errors;
        r0 = rd_cnt;
        write_word(32'h0000_2088, 8'b1100_0110, lat); // Refill bytes kept where strobe is clear
        check_eq(64'(rd_cnt - r0), 64'd1, "refill on write miss");
        check_eq(64'(rd_addr), 64'h2080, "write miss refill address");
        for (int k = 0; k < 8; k++) read_check(32'h0000_2080 + k * 8, lat);
        check_eq(64'(rd_cnt - r0), 64'd1, "no refill on rereads");
        report("write miss allocates", e);
    endtask

    task automatic test_dirty_evict();
        int e, lat, w0;
        logic hit;
        e  = errors;
        w0 = wb_cnt;
        for (int t = 1; t <= 4; t++) write_word((t << 10) | (5 << 6) | 8 * t, 8'hff, lat);
        write_word((5 << 10) | (5 << 6), 8'h3c, lat);
        check_eq(64'(wb_cnt - w0), 64'd1, "writeback count");
        hit = 1'b0;
        for (int t = 1; t <= 4; t++) if (wb_addr == ((t << 10) | (5 << 6))) hit = 1'b1;
        check_eq(64'(hit), 64'd1, "writeback address is a dirty block");
        for (int k = 0; k < 8; k++) check_eq(wb_data[k], exp_dw(wb_addr + k * 8), "wb beat");
        for (int t = 1; t <= 4; t++) read_check((t << 10) | (5 << 6) | 8 * t, lat);
        read_check((5 << 10) | (5 << 6), lat);
        report("dirty eviction", e);
    endtask

    task automatic test_clean_evict();
        int e, lat, w0;
        e  = errors;
        w0 = wb_cnt;
        for (int t = 1; t <= 5; t++) read_check((t << 10) | (7 << 6) | 16, lat);
        check_eq(64'(wb_cnt - w0), 64'd0, "clean set writeback count");
        read_check(32'h0000_0200, lat);        // Set 8
        read_check(32'h0000_0c10, lat);        // Set 0
        read_check(32'h0000_1048, lat);        // Set 1 still resident
        check_eq(64'(lat), 64'd2, "set 1 hit after other sets");
        read_check(32'h0000_2090, lat);
        check_eq(64'(lat), 64'd2, "set 2 hit after other sets");
        report("clean eviction, set independence", e);
    endtask

    initial begin
        void'($urandom(SEED));
        key       = $urandom;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        failed    = 0;
        wb_cnt    = 0;
        rd_cnt    = 0;
        wb_beat   = 0;
        rst_n     = 1'b0;
        fill_en   = 1'b1;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n   = 1'b1;
        fill_en = 1'b0;
        test_read_miss_hit();
        test_write_hit();
        test_write_miss();
        test_dirty_evict();
        test_clean_evict();
        $display("tests %0d failed %0d checks %0d errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tb/cache_chk.sv
// Concurrent assertions on the cache controller and their bind
`timescale 1ns/1ps

module cache_chk (
    input logic clk,
    input logic rst_n,
    input logic cpu_done,
    input logic mem_rd,
    input logic mem_wvalid
);

    int run_len;                              // Length of current mem_wvalid run

    always_ff @(posedge clk) begin
        if (!rst_n) run_len <= 0;
        else if (mem_wvalid) run_len <= run_len + 1;
        else run_len <= 0;
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_done |=> !cpu_done) else $error("cpu_done longer than one cycle");

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_rd && mem_wvalid)) else $error("mem_rd and mem_wvalid together");

    a_wb_max: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wvalid |-> run_len < 8) else $error("writeback run above eight beats");

    a_wb_len: assert property (@(posedge clk) disable iff (!rst_n)
        (!mem_wvalid && run_len != 0) |-> run_len == 8) else $error("short writeback run");

    // State is in reset one cycle after rst_n is seen low
    a_rst_done: assert property (@(posedge clk)
        !rst_n |=> !cpu_done) else $error("cpu_done high in reset");

endmodule

bind cache_ctrl cache_chk u_chk (.*);

// File: tb/cache_mem_model.sv
// Backing memory model with spaced refill beats and writeback capture
`timescale 1ns/1ps

module cache_mem_model
    import cache_pkg::*;
#(
    parameter int LATENCY = 6                // Cycles from mem_rd to first beat
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fill_en,       // Loads the start pattern
    input  logic [31:0]       fill_key,      // Run key from $urandom
    input  logic              mem_rd,
    input  logic [ADDR_W-1:0] mem_addr,
    output logic              mem_rvalid,
    output logic [DATA_W-1:0] mem_rdata,
    input  logic              mem_wvalid,
    input  logic [DATA_W-1:0] mem_wdata
);

    logic [DATA_W-1:0] mem [8192];            // 64 KB as doublewords
    logic [9:0]        rd_blk;
    logic [2:0]        rd_beat, wb_beat;
    logic              rd_busy, gap;
    int                delay;

    always_ff @(posedge clk) begin
        mem_rvalid <= 1'b0;
        if (fill_en) begin
            for (int i = 0; i < 8192; i++) begin
                mem[i] <= {fill_key ^ (i * 32'h9e3779b1), ~fill_key ^ (i * 32'h7f4a7c15) ^ i};
            end
        end
        if (!rst_n) begin
            rd_busy <= 1'b0;
            wb_beat <= '0;
            gap     <= 1'b0;
        end else begin
            if (mem_wvalid) begin
                mem[{mem_addr[15:6], wb_beat}] <= mem_wdata; // One beat per cycle
                wb_beat <= wb_beat + 1'b1;
            end
            if (mem_rd) begin
                rd_blk  <= mem_addr[15:6];
                rd_beat <= '0;
                delay   <= LATENCY;
                gap     <= 1'b0;
                rd_busy <= 1'b1;
            end else if (rd_busy) begin
                if (delay != 0) begin
                    delay <= delay - 1;
                end else if (!gap) begin
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= mem[{rd_blk, rd_beat}];
                    rd_beat    <= rd_beat + 1'b1;
                    gap        <= 1'b1;       // Idle cycle between beats
                    if (rd_beat == 3'd7) rd_busy <= 1'b0;
                end else begin
                    gap <= 1'b0;
                end
            end
        end
    end

endmodule

// File: source/cache_top.sv
// Cache top level connecting controller, tag array and data store
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_req,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic              cpu_we,
    input  logic [DATA_W-1:0] cpu_wdata,
    input  logic [STRB_W-1:0] cpu_wstrb,
    output logic [DATA_W-1:0] cpu_rdata,
    output logic              cpu_done,
    output logic              cpu_busy,
    output logic              mem_rd,
    output logic [ADDR_W-1:0] mem_addr,
    input  logic              mem_rvalid,
    input  logic [DATA_W-1:0] mem_rdata,
    output logic              mem_wvalid,
    output logic [DATA_W-1:0] mem_wdata
);

    // Controller to tag array
    logic [INDEX_W-1:0]  tag_index;
    logic [TAG_W-1:0]    tag_addr_tag, tag_vic_tag;
    logic                tag_hit, tag_inv_found, tag_vic_valid, tag_vic_dirty;
    logic [WAY_W-1:0]    tag_hit_way, tag_inv_way, tag_vic_way, tag_w_way;
    logic                tag_we, tag_w_valid, tag_w_dirty;
    // Controller to data store
    logic [WAY_W-1:0]    sram_way;
    logic [INDEX_W-1:0]  sram_index;
    logic [OFFSET_W-1:0] sram_offset, sram_offset_r;
    logic                sram_r_en, sram_w_en;
    logic [DATA_W-1:0]   sram_wdata, sram_rdata;
    logic [STRB_W-1:0]   sram_wstrb;

    cache_ctrl u_ctrl (.*);

    cache_tag u_tag (
        .clk(clk), .rst_n(rst_n), .index(tag_index), .addr_tag(tag_addr_tag),
        .hit(tag_hit), .hit_way(tag_hit_way), .inv_found(tag_inv_found),
        .inv_way(tag_inv_way), .vic_way(tag_vic_way), .vic_valid(tag_vic_valid),
        .vic_dirty(tag_vic_dirty), .vic_tag(tag_vic_tag), .we(tag_we),
        .w_way(tag_w_way), .w_valid(tag_w_valid), .w_dirty(tag_w_dirty)
    );

    cache_sram u_sram (
        .clk(clk), .way(sram_way), .index(sram_index), .offset(sram_offset),
        .offset_r(sram_offset_r), .sram_r_en(sram_r_en), .sram_w_en(sram_w_en),
        .sram_w_data(sram_wdata), .sram_w_strb(sram_wstrb), .sram_r_data(sram_rdata)
    );

endmodule

// File: source/cache_ctrl.sv
// Cache controller FSM with lookup, victim writeback, refill, response and LFSR victim choice
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    // CPU side
    input  logic                cpu_req,
    input  logic [ADDR_W-1:0]   cpu_addr,
    input  logic                cpu_we,
    input  logic [DATA_W-1:0]   cpu_wdata,
    input  logic [STRB_W-1:0]   cpu_wstrb,
    output logic [DATA_W-1:0]   cpu_rdata,
    output logic                cpu_done,
    output logic                cpu_busy,
    // Memory side
    output logic                mem_rd,
    output logic [ADDR_W-1:0]   mem_addr,
    input  logic                mem_rvalid,
    input  logic [DATA_W-1:0]   mem_rdata,
    output logic                mem_wvalid,
    output logic [DATA_W-1:0]   mem_wdata,
    // Tag array
    output logic [INDEX_W-1:0]  tag_index,
    output logic [TAG_W-1:0]    tag_addr_tag,
    input  logic                tag_hit,
    input  logic [WAY_W-1:0]    tag_hit_way,
    input  logic                tag_inv_found,
    input  logic [WAY_W-1:0]    tag_inv_way,
    output logic [WAY_W-1:0]    tag_vic_way,
    input  logic                tag_vic_valid,
    input  logic                tag_vic_dirty,
    input  logic [TAG_W-1:0]    tag_vic_tag,
    output logic                tag_we,
    output logic [WAY_W-1:0]    tag_w_way,
    output logic                tag_w_valid,
    output logic                tag_w_dirty,
    // Data store
    output logic [WAY_W-1:0]    sram_way,
    output logic [INDEX_W-1:0]  sram_index,
    output logic [OFFSET_W-1:0] sram_offset,
    output logic [OFFSET_W-1:0] sram_offset_r,
    output logic                sram_r_en,
    output logic                sram_w_en,
    output logic [DATA_W-1:0]   sram_wdata,
    output logic [STRB_W-1:0]   sram_wstrb,
    input  logic [DATA_W-1:0]   sram_rdata
);

    cache_state_e          state, state_nxt;
    logic [ADDR_W-1:0]     req_addr;
    logic                  req_we;
    logic [DATA_W-1:0]     req_wdata;
    logic [STRB_W-1:0]     req_wstrb;
    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_W-1:0]    req_index;
    logic [OFFSET_W-1:0]   req_offset;
    logic [7:0]            lfsr;
    logic [WAY_W-1:0]      vic_pick;
    logic [WAY_W-1:0]      vic_way_r;
    logic [BEAT_W-1:0]     beat_cnt;
    logic [BEAT_W-1:0]     beat_nxt;
    logic                  beat_last;
    logic                  acc_hit;
    logic                  lookup_miss;
    logic                  vic_wb;

    assign req_tag    = req_addr[ADDR_W-1 -: TAG_W];
    assign req_index  = req_addr[OFFSET_W +: INDEX_W];
    assign req_offset = req_addr[OFFSET_W-1:0];

    assign acc_hit     = (state == ST_LOOKUP || state == ST_ACCESS) && tag_hit;
    assign lookup_miss = (state == ST_LOOKUP) && !tag_hit;
    assign vic_pick    = tag_inv_found ? tag_inv_way : lfsr[WAY_W-1:0]; // Free way first
    assign vic_wb      = tag_vic_valid && tag_vic_dirty;
    assign beat_nxt    = beat_cnt + 1'b1;
    assign beat_last   = (beat_cnt == BEAT_W'(BEAT_NUM - 1));

    // CPU handshake
    assign cpu_busy  = (state != ST_IDLE);
    assign cpu_done  = (state == ST_RESPOND);
    assign cpu_rdata = sram_rdata;           // Valid in ST_RESPOND

    // Memory side
    assign mem_rd     = (state == ST_REFILL_REQ);
    assign mem_wvalid = (state == ST_WB_SEND);
    assign mem_wdata  = sram_rdata;          // Beat read one cycle earlier
    assign mem_addr   = (state == ST_WB_SEND) ? {tag_vic_tag, req_index, {OFFSET_W{1'b0}}}
                                              : {req_tag, req_index, {OFFSET_W{1'b0}}};

    // Tag array controls
    assign tag_index    = req_index;
    assign tag_addr_tag = req_tag;
    assign tag_vic_way  = (state == ST_LOOKUP) ? vic_pick : vic_way_r;
    assign tag_we       = (acc_hit && req_we) || (state == ST_REFILL_WAIT && mem_rvalid && beat_last);
    assign tag_w_way    = acc_hit ? tag_hit_way : vic_way_r;
    assign tag_w_valid  = 1'b1;                   // Only fills and stores update
    assign tag_w_dirty  = acc_hit && req_we;      // Clean after refill

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:        if (cpu_req) state_nxt = ST_LOOKUP;
            ST_LOOKUP: begin
                if (tag_hit) begin
                    state_nxt = ST_RESPOND;
                end else if (vic_wb) begin
                    state_nxt = ST_WB_SEND;
                end else begin
                    state_nxt = ST_REFILL_REQ;
                end
            end
            ST_WB_SEND:     if (beat_last) state_nxt = ST_REFILL_REQ;
            ST_REFILL_REQ:  state_nxt = ST_REFILL_WAIT;
            ST_REFILL_WAIT: if (mem_rvalid && beat_last) state_nxt = ST_ACCESS;
            ST_ACCESS:      state_nxt = ST_RESPOND;
            ST_RESPOND:     state_nxt = ST_IDLE;
            default:        state_nxt = ST_IDLE;
        endcase
    end

    // Data store controls
    always_comb begin
        sram_way    = vic_way_r;
        sram_index  = req_index;
        sram_offset = {beat_cnt, {(OFFSET_W - BEAT_W){1'b0}}}; // Refill beat position
        sram_r_en   = 1'b0;
        sram_w_en   = 1'b0;
        sram_wdata  = mem_rdata;
        sram_wstrb  = '1;                                    // Whole doubleword on refill
        case (state)
            ST_LOOKUP, ST_ACCESS: begin
                if (tag_hit) begin
                    sram_way    = tag_hit_way;
                    sram_offset = req_offset;
                    sram_r_en   = !req_we;
                    sram_w_en   = req_we;
                    sram_wdata  = req_wdata;
                    sram_wstrb  = req_wstrb;
                end else if (state == ST_LOOKUP && vic_wb) begin
                    sram_way    = vic_pick;                  // Prefetch beat 0 of victim
                    sram_offset = '0;
                    sram_r_en   = 1'b1;
                end
            end
            ST_WB_SEND: begin
                sram_offset = {beat_nxt, {(OFFSET_W - BEAT_W){1'b0}}}; // Next beat
                sram_r_en   = !beat_last;
            end
            ST_REFILL_WAIT: sram_w_en = mem_rvalid;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            lfsr     <= LFSR_SEED;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            lfsr  <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]}; // x^8+x^6+x^5+x^4+1
            if (state == ST_LOOKUP) begin
                beat_cnt <= '0;
            end else if (state == ST_WB_SEND || (state == ST_REFILL_WAIT && mem_rvalid)) begin
                beat_cnt <= beat_nxt;                    // Wraps to 0 after beat 7
            end
        end
    end

    // Request and victim payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cpu_req) begin
            req_addr  <= cpu_addr;
            req_we    <= cpu_we;
            req_wdata <= cpu_wdata;
            req_wstrb <= cpu_wstrb;
        end
        if (lookup_miss) begin
            vic_way_r <= vic_pick;
        end
        if (sram_r_en) begin
            sram_offset_r <= sram_offset; // Follows data through the read stage
        end
    end

endmodule

// File: source/cache_tag.sv
// Tag array with valid and dirty bits, hit compare, invalid-way search and victim readout
`timescale 1ns/1ps

module cache_tag
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [INDEX_W-1:0] index,
    input  logic [TAG_W-1:0]   addr_tag,  // Compare value and write value
    output logic               hit,
    output logic [WAY_W-1:0]   hit_way,
    output logic               inv_found,
    output logic [WAY_W-1:0]   inv_way,   // Lowest invalid way
    input  logic [WAY_W-1:0]   vic_way,
    output logic               vic_valid,
    output logic               vic_dirty,
    output logic [TAG_W-1:0]   vic_tag,
    input  logic               we,
    input  logic [WAY_W-1:0]   w_way,
    input  logic               w_valid,
    input  logic               w_dirty
);

    logic [WAY_NUM-1:0] valid_q [(1 << INDEX_W)]; // Per set, one bit per way
    logic [WAY_NUM-1:0] dirty_q [(1 << INDEX_W)];
    logic [TAG_W-1:0]   tag_q   [(1 << INDEX_W)][WAY_NUM];
    logic [WAY_NUM-1:0] hit_vec;

    // Status bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < (1 << INDEX_W); s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (we) begin
            valid_q[index][w_way] <= w_valid;
            dirty_q[index][w_way] <= w_dirty;
        end
    end

    // Stored tags
    always_ff @(posedge clk) begin
        if (we) begin
            tag_q[index][w_way] <= addr_tag;
        end
    end

    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            hit_vec[w] = valid_q[index][w] && (tag_q[index][w] == addr_tag);
        end
    end

    assign hit = |hit_vec;

    // Walk down so the lowest matching way is the one left
    always_comb begin
        hit_way   = '0;
        inv_found = 1'b0;
        inv_way   = '0;
        for (int w = WAY_NUM - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                hit_way = WAY_W'(w);
            end
            if (!valid_q[index][w]) begin
                inv_found = 1'b1;
                inv_way   = WAY_W'(w);
            end
        end
    end

    // Victim fields for the writeback decision and address
    assign vic_valid = valid_q[index][vic_way];
    assign vic_dirty = dirty_q[index][vic_way];
    assign vic_tag   = tag_q[index][vic_way];

endmodule

// File: source/cache_sram.sv
// Cache data store with four SRAM banks, write steering and read-data selection
`timescale 1ns/1ps

module cache_sram
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic [WAY_W-1:0]    way,
    input  logic [INDEX_W-1:0]  index,
    input  logic [OFFSET_W-1:0] offset,      // Offset of this cycle's access
    input  logic [OFFSET_W-1:0] offset_r,    // Offset of last cycle's read
    input  logic                sram_r_en,
    input  logic                sram_w_en,
    input  logic [DATA_W-1:0]   sram_w_data,
    input  logic [STRB_W-1:0]   sram_w_strb, // One bit per byte
    output logic [DATA_W-1:0]   sram_r_data
);

    logic                bank_cen;
    logic [3:0]          bank_wen;
    logic [SRAM_DW-1:0]  bank_bwen;
    logic [SRAM_DW-1:0]  bank_wdata;
    logic [DATA_W-1:0]   strb_bits;
    logic [SRAM_DW-1:0]  bank_rdata [4];
    logic [SRAM_DW-1:0]  rd_word;

    // Byte strobes widened to a bit mask
    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            strb_bits[i*8 +: 8] = {8{sram_w_strb[i]}};
        end
    end

    assign bank_cen   = ~(sram_r_en | sram_w_en);              // All banks on any access
    assign bank_wen   = ~({3'b000, sram_w_en} << offset[5:4]); // Only the addressed bank
    assign bank_wdata = {2{sram_w_data}};                      // Same doubleword in both halves
    assign bank_bwen  = offset[3] ? ~{strb_bits, {DATA_W{1'b0}}}
                                  : ~{{DATA_W{1'b0}}, strb_bits}; // Mask the other half

    for (genvar b = 0; b < 4; b++) begin : g_bank
        sram_sp_32x128_bw u_bank (
            .clk  (clk),
            .cen  (bank_cen),
            .wen  (bank_wen[b]),
            .bwen (bank_bwen),
            .a    ({way, index}),
            .d    (bank_wdata),
            .q    (bank_rdata[b])
        );
    end

    // Bank by offset 5..4, half by offset 3
    assign rd_word     = bank_rdata[offset_r[5:4]];
    assign sram_r_data = offset_r[3] ? rd_word[SRAM_DW-1:DATA_W] : rd_word[DATA_W-1:0];

endmodule

// File: source/sram_sp_32x128_bw.sv
// Behavioral single-port 128-bit SRAM with active-low enables and bit write mask
`timescale 1ns/1ps

module sram_sp_32x128_bw
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               cen,  // Chip enable, low active
    input  logic               wen,  // Write enable, low active
    input  logic [SRAM_DW-1:0] bwen, // Bit write mask, 0 writes the bit
    input  logic [SRAM_AW-1:0] a,
    input  logic [SRAM_DW-1:0] d,
    output logic [SRAM_DW-1:0] q
);

    // 32 rows by 2 column mux, seen here as one flat word array
    logic [SRAM_DW-1:0] mem [(1 << SRAM_AW)];

    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[a] <= (mem[a] & bwen) | (d & ~bwen); // Masked bits kept
            end else begin
                q <= mem[a];                             // Registered read
            end
        end
        // q holds while the bank is idle or writing
    end

endmodule

// File: source/cache_pkg.sv
// Cache geometry constants, LFSR seed and controller state type
package cache_pkg;

    // Bus widths
    localparam int ADDR_W    = 32;         // CPU and memory byte address
    localparam int DATA_W    = 64;         // One doubleword
    localparam int STRB_W    = DATA_W / 8; // Byte strobes per doubleword

    // Address split, tag | index | offset
    localparam int TAG_W     = 22;         // Address bits 31..10
    localparam int INDEX_W   = 4;          // 16 sets
    localparam int OFFSET_W  = 6;          // 64-byte block

    // Associativity
    localparam int WAY_NUM   = 4;
    localparam int WAY_W     = 2;          // Way number width

    // Block transfer on the memory side
    localparam int BEAT_NUM  = 8;          // Doublewords per block
    localparam int BEAT_W    = 3;          // Beat counter

    // Data store banks
    localparam int SRAM_AW   = WAY_W + INDEX_W; // {way, index}
    localparam int SRAM_DW   = 128;             // Two doublewords per bank word

    // Replacement
    localparam logic [7:0] LFSR_SEED = 8'hA5;   // Any non-zero value

    // Controller states
    typedef enum logic [2:0] {
        ST_IDLE,        // Waiting for cpu_req
        ST_LOOKUP,      // Tag compare, hit access
        ST_WB_SEND,     // Dirty victim out, eight beats
        ST_REFILL_REQ,  // mem_rd pulse
        ST_REFILL_WAIT, // Collecting beats into the victim way
        ST_ACCESS,      // Replay of the request as a hit
        ST_RESPOND      // cpu_done with read data
    } cache_state_e;

endpackage
